/* all.f */
hdl/isaPkg.sv
hdl/corePkg.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/aluExec.sv
hdl/execCore.sv
dv/tbExecCore.sv

/* dv/tbExecCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbExecCore;
    import isaPkg::*;
    import corePkg::*;

    localparam int randomCount  = 300;
    localparam int drainTimeout = 10;
    localparam logic [31:0] seed = 32'h0c524858;

    typedef struct packed {
        int      due;    // Cycle the strobe must show up.
        result_t res;
    } expEntry_t;

    logic       clk;
    logic       rst;
    logic       instrValid;
    instrWord_t instr;
    logic       resultValid;
    result_t    result;
    regAddr_t   debugReg;
    data_t      debugData;

    data_t     shadow [0:regCount-1];
    expEntry_t expQ[$];
    int        cycle;
    int        valueErrors;
    int        timingErrors;
    int        timeoutErrors;

    execCore u_execCore (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .debugReg    (debugReg),
        .debugData   (debugData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoding and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Returns 0 for a word the core must drop.
    function automatic logic modelExec(input logic [31:0] w, output result_t res);
        data_t    a, b, sx, zx, v;
        logic     legal;
        regAddr_t dest;
        a     = shadow[w[25:21]];
        b     = shadow[w[20:16]];
        sx    = {{16{w[15]}}, w[15:0]};
        zx    = {16'h0000, w[15:0]};
        v     = '0;
        legal = 1'b1;
        dest  = w[20:16];
        case (w[31:26])
            6'h00: begin
                dest = w[15:11];
                case (w[5:0])
                    6'h00:   v = b << w[10:6];
                    6'h02:   v = b >> w[10:6];
                    6'h20:   v = a + b;
                    6'h22:   v = a - b;
                    6'h24:   v = a & b;
                    6'h25:   v = a | b;
                    6'h26:   v = a ^ b;
                    6'h2A:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: legal = 1'b0;
                endcase
            end
            6'h08:   v = a + sx;
            6'h0A:   v = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            6'h0C:   v = a & zx;
            6'h0D:   v = a | zx;
            6'h0E:   v = a ^ zx;
            6'h0F:   v = {w[15:0], 16'h0000};
            default: legal = 1'b0;
        endcase
        res.dest  = dest;
        res.value = v;
        return legal;
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [4:0]  rs, rt, rd, sh;
        logic [15:0] imm;
        logic [31:0] w;
        rs  = 5'($urandom_range(0, 7));    // Few registers, many hazards.
        rt  = 5'($urandom_range(0, 7));
        rd  = 5'($urandom_range(0, 7));
        sh  = 5'($urandom_range(0, 31));
        imm = 16'($urandom);
        case ($urandom_range(0, 15))
            0:       w = rWord(fnSll, rs, rt, rd, sh);
            1:       w = rWord(fnSrl, rs, rt, rd, sh);
            2:       w = rWord(fnAdd, rs, rt, rd, sh);
            3:       w = rWord(fnSub, rs, rt, rd, sh);
            4:       w = rWord(fnAnd, rs, rt, rd, sh);
            5:       w = rWord(fnOr, rs, rt, rd, sh);
            6:       w = rWord(fnXor, rs, rt, rd, sh);
            7:       w = rWord(fnSlt, rs, rt, rd, sh);
            8:       w = iWord(opAddi, rs, rt, imm);
            9:       w = iWord(opSlti, rs, rt, imm);
            10:      w = iWord(opAndi, rs, rt, imm);
            11:      w = iWord(opOri, rs, rt, imm);
            12:      w = iWord(opXori, rs, rt, imm);
            13:      w = iWord(opLui, rs, rt, imm);
            14:      w = iWord(6'h23, rs, rt, imm);    // Load opcode, not supported.
            default: w = rWord(6'h18, rs, rt, rd, sh);    // Multiply funct.
        endcase
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue(input logic [31:0] w);
        result_t   res;
        expEntry_t entry;
        @(negedge clk);
        instrValid = 1'b1;
        instr      = w;
        if (modelExec(w, res)) begin
            entry.due = cycle + 2;
            entry.res = res;
            expQ.push_back(entry);
            if (res.dest != '0) begin
                shadow[res.dest] = res.value;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    task automatic readReg(input int idx, output data_t val);
        @(negedge clk);
        instrValid = 1'b0;
        debugReg   = regAddr_t'(idx);
        @(negedge clk);
        val = debugData;
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < drainTimeout) begin
            idle(1);
            waited++;
        end
        if (expQ.size() > 0) begin
            $display("Timed out with %0d results still outstanding", expQ.size());
            timeoutErrors++;
        end
    endtask

    task automatic checkAllRegs(input logic expectZero);
        data_t val;
        data_t exp;
        for (int r = 0; r < regCount; r++) begin
            readReg(r, val);
            exp = expectZero ? '0 : shadow[r];
            assert (val === exp) else begin
                $display("** Error: debugData r%0d got 0x%08h expected 0x%08h", r, val, exp);
                valueErrors++;
            end
        end
    endtask

    // Result monitor, sampled on falling edges.
    always @(negedge clk) begin
        expEntry_t entry;
        if (!rst && resultValid) begin
            assert (expQ.size() > 0) else begin
                $display("resultValid strobed with no instruction in flight");
                timingErrors++;
            end
            if (expQ.size() > 0) begin
                entry = expQ.pop_front();
                assert (entry.due == cycle) else begin
                    $display("resultValid came at cycle %0d, due at cycle %0d", cycle, entry.due);
                    timingErrors++;
                end
                assert (result === entry.res) else begin
                    $display("** Error: result dest=0x%02h value=0x%08h expected 0x%02h 0x%08h",
                             result.dest, result.value, entry.res.dest, entry.res.value);
                    valueErrors++;
                end
            end
        end else if (!rst && expQ.size() > 0) begin
            assert (expQ[0].due > cycle) else begin
                $display("resultValid missing for the instruction due at cycle %0d", expQ[0].due);
                timingErrors++;
                void'(expQ.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(seed));
        rst           = 1'b1;
        instrValid    = 1'b0;
        instr         = '0;
        debugReg      = '0;
        cycle         = 0;
        valueErrors   = 0;
        timingErrors  = 0;
        timeoutErrors = 0;
        for (int r = 0; r < regCount; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        assert (resultValid === 1'b0) else begin
            $display("** Error: resultValid after reset is 0x%h, expected 0x0", resultValid);
            valueErrors++;
        end
        checkAllRegs(1'b1);

        // Directed ops with distance-one and distance-two hazards.
        issue(iWord(opLui, 5'd0, 5'd1, 16'h8000));
        issue(iWord(opOri, 5'd1, 5'd1, 16'h0001));
        issue(iWord(opAddi, 5'd0, 5'd2, 16'hFFFF));    // Sign extended to -1.
        issue(rWord(fnSlt, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(iWord(opSlti, 5'd2, 5'd4, 16'h0000));
        issue(iWord(opAndi, 5'd2, 5'd5, 16'h8001));    // Zero extended.
        issue(iWord(opXori, 5'd2, 5'd6, 16'h00FF));
        issue(rWord(fnSll, 5'd0, 5'd2, 5'd7, 5'd4));
        issue(rWord(fnSrl, 5'd0, 5'd2, 5'd8, 5'd28));
        issue(rWord(fnSub, 5'd8, 5'd1, 5'd9, 5'd0));
        issue(rWord(fnAdd, 5'd9, 5'd9, 5'd10, 5'd0));
        issue(rWord(fnOr, 5'd10, 5'd9, 5'd11, 5'd0));
        issue(rWord(fnXor, 5'd11, 5'd10, 5'd12, 5'd0));
        issue(iWord(opAddi, 5'd1, 5'd0, 16'h0005));    // Writes r0, still strobes.
        issue(rWord(fnAdd, 5'd0, 5'd0, 5'd13, 5'd0));
        issue(iWord(6'h2B, 5'd1, 5'd2, 16'h0010));    // Store opcode, dropped.
        issue(rWord(6'h1A, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(rWord(fnSlt, 5'd2, 5'd1, 5'd14, 5'd0));
        idle(1);
        issue(rWord(fnAdd, 5'd12, 5'd13, 5'd15, 5'd0));
        idle(3);

        for (int n = 0; n < randomCount; n++) begin
            issue(randomInstr());
            if ($urandom_range(0, 2) == 0) begin
                idle($urandom_range(1, 3));
            end
        end

        drainResults();
        checkAllRegs(1'b0);

        $display("Errors: %0d value, %0d timing, %0d timeout",
                 valueErrors, timingErrors, timeoutErrors);
        if (valueErrors + timingErrors + timeoutErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/aluExec.sv */
`timescale 1ns/1ps
`default_nettype none

module aluExec (
    input  logic                clk,
    input  logic                rst,
    input  logic                decValid,
    input  corePkg::decodedOp_t decOp,
    output logic                fwdValid,
    output corePkg::result_t    fwdResult,
    output logic                resultValid,
    output corePkg::result_t    result
);
    import isaPkg::*;
    import corePkg::*;

    data_t aluValue;
    logic  lessThan;

    assign lessThan = $signed(decOp.opA) < $signed(decOp.opB);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result compute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (decOp.aluOp)
            aluAdd:  aluValue = decOp.opA + decOp.opB;    // Wraps.
            aluSub:  aluValue = decOp.opA - decOp.opB;
            aluAnd:  aluValue = decOp.opA & decOp.opB;
            aluOr:   aluValue = decOp.opA | decOp.opB;
            aluXor:  aluValue = decOp.opA ^ decOp.opB;
            aluSlt:  aluValue = {{(dataWidth-1){1'b0}}, lessThan};
            aluSll:  aluValue = decOp.opB << decOp.shamt;    // Shifts act on rt.
            aluSrl:  aluValue = decOp.opB >> decOp.shamt;
            aluLui:  aluValue = decOp.opB << immWidth;
            default: aluValue = '0;
        endcase
    end

    // Forward path for the op in flight.
    assign fwdValid        = decValid;
    assign fwdResult.dest  = decOp.dest;
    assign fwdResult.value = aluValue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            result.dest  <= decOp.dest;
            result.value <= aluValue;
        end
    end

endmodule

`default_nettype wire

/* hdl/corePkg.sv */
`default_nettype none

package corePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operations understood by the execute stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,    // Signed compare.
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluLui = 4'd8
    } aluOp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Decode to execute.
    typedef struct packed {
        aluOp_t                        aluOp;
        isaPkg::regAddr_t              dest;
        isaPkg::data_t                 opA;    // Rs value.
        isaPkg::data_t                 opB;    // Rt value or extended immediate.
        logic [isaPkg::shamtWidth-1:0] shamt;
    } decodedOp_t;

    // Execute to register file and outside.
    typedef struct packed {
        isaPkg::regAddr_t dest;
        isaPkg::data_t    value;
    } result_t;

endpackage

`default_nettype wire

/* hdl/execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  isaPkg::instrWord_t instr,
    output logic               resultValid,
    output corePkg::result_t   result,
    input  isaPkg::regAddr_t   debugReg,
    output isaPkg::data_t      debugData
);
    import isaPkg::*;
    import corePkg::*;

    regAddr_t   rsAddr;
    regAddr_t   rtAddr;
    data_t      rsData;
    data_t      rtData;
    logic       decValid;
    decodedOp_t decOp;
    logic       fwdValid;
    result_t    fwdResult;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    instrDecode u_instrDecode (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .rsData      (rsData),
        .rtData      (rtData),
        .fwdValid    (fwdValid),
        .fwdResult   (fwdResult),
        .resultValid (resultValid),
        .result      (result),
        .decValid    (decValid),
        .decOp       (decOp)
    );

    aluExec u_aluExec (
        .clk         (clk),
        .rst         (rst),
        .decValid    (decValid),
        .decOp       (decOp),
        .fwdValid    (fwdValid),
        .fwdResult   (fwdResult),
        .resultValid (resultValid),
        .result      (result)
    );

    // Result strobe doubles as the write port.
    regFile u_regFile (
        .clk         (clk),
        .rst         (rst),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .rsData      (rsData),
        .rtData      (rtData),
        .resultValid (resultValid),
        .result      (result),
        .debugReg    (debugReg),
        .debugData   (debugData)
    );

endmodule

`default_nettype wire

/* hdl/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrValid,
    input  isaPkg::instrWord_t  instr,
    output isaPkg::regAddr_t    rsAddr,
    output isaPkg::regAddr_t    rtAddr,
    input  isaPkg::data_t       rsData,
    input  isaPkg::data_t       rtData,
    input  logic                fwdValid,
    input  corePkg::result_t    fwdResult,
    input  logic                resultValid,
    input  corePkg::result_t    result,
    output logic                decValid,
    output corePkg::decodedOp_t decOp
);
    import isaPkg::*;
    import corePkg::*;

    aluOp_t     aluOp;
    regAddr_t   dest;
    logic       legal;
    logic       useImm;
    logic       signExt;
    data_t      immExt;
    data_t      rsVal;
    data_t      rtVal;
    decodedOp_t decNext;

    // Newest value wins; register 0 is never bypassed.
    function automatic data_t pickOperand(
        input regAddr_t src,
        input data_t    regData,
        input logic     exValid,
        input result_t  exResult,
        input logic     wbValid,
        input result_t  wbResult
    );
        data_t val;
        if (src == '0) begin
            val = '0;
        end else if (exValid && exResult.dest == src) begin
            val = exResult.value;
        end else if (wbValid && wbResult.dest == src) begin
            val = wbResult.value;
        end else begin
            val = regData;
        end
        return val;
    endfunction

    assign rsAddr = instr.rFmt.rs;
    assign rtAddr = instr.rFmt.rt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode and function decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        aluOp   = aluAdd;
        dest    = instr.iFmt.rt;    // Immediate format writes rt.
        legal   = 1'b1;
        useImm  = 1'b1;
        signExt = 1'b0;
        case (instr.rFmt.opcode)
            opRType: begin
                dest   = instr.rFmt.rd;
                useImm = 1'b0;
                case (instr.rFmt.funct)
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    default: legal = 1'b0;
                endcase
            end
            opAddi: begin
                aluOp   = aluAdd;
                signExt = 1'b1;
            end
            opSlti: begin
                aluOp   = aluSlt;
                signExt = 1'b1;
            end
            opAndi:  aluOp = aluAnd;
            opOri:   aluOp = aluOr;
            opXori:  aluOp = aluXor;
            opLui:   aluOp = aluLui;
            default: legal = 1'b0;    // Dropped, no strobes.
        endcase
    end

    assign immExt = signExt
        ? {{(dataWidth-immWidth){instr.iFmt.imm[immWidth-1]}}, instr.iFmt.imm}
        : {{(dataWidth-immWidth){1'b0}}, instr.iFmt.imm};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rsVal = pickOperand(rsAddr, rsData, fwdValid, fwdResult, resultValid, result);
        rtVal = pickOperand(rtAddr, rtData, fwdValid, fwdResult, resultValid, result);
    end

    always_comb begin
        decNext.aluOp = aluOp;
        decNext.dest  = dest;
        decNext.opA   = rsVal;
        decNext.opB   = useImm ? immExt : rtVal;
        decNext.shamt = instr.rFmt.shamt;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            decOp <= decNext;
        end
    end

endmodule

`default_nettype wire

/* hdl/isaPkg.sv */
`default_nettype none

package isaPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Architectural sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int regCount     = 32;
    localparam int regAddrWidth = 5;
    localparam int dataWidth    = 32;
    localparam int shamtWidth   = 5;
    localparam int immWidth     = 16;

    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [dataWidth-1:0]    data_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        opRType = 6'h00,    // Function field selects the op.
        opAddi  = 6'h08,
        opSlti  = 6'h0A,
        opAndi  = 6'h0C,
        opOri   = 6'h0D,
        opXori  = 6'h0E,
        opLui   = 6'h0F
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2A
    } funct_t;

    typedef struct packed {
        opcode_t               opcode;
        regAddr_t              rs;
        regAddr_t              rt;
        regAddr_t              rd;
        logic [shamtWidth-1:0] shamt;
        funct_t                funct;
    } rFormat_t;

    typedef struct packed {
        opcode_t             opcode;
        regAddr_t            rs;
        regAddr_t            rt;
        logic [immWidth-1:0] imm;
    } iFormat_t;

    // Same 32 bits, two views.
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
    } instrWord_t;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  isaPkg::regAddr_t rsAddr,
    input  isaPkg::regAddr_t rtAddr,
    output isaPkg::data_t    rsData,
    output isaPkg::data_t    rtData,
    input  logic             resultValid,
    input  corePkg::result_t result,
    input  isaPkg::regAddr_t debugReg,
    output isaPkg::data_t    debugData
);
    import isaPkg::*;

    // No storage behind register 0.
    data_t regs [1:regCount-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (resultValid && result.dest != '0) begin
            regs[result.dest] <= result.value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Committed state only; bypass is done in decode.
    assign rsData    = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData    = (rtAddr == '0) ? '0 : regs[rtAddr];
    assign debugData = (debugReg == '0) ? '0 : regs[debugReg];    // Architectural readout.

endmodule

`default_nettype wire
